// ==== dv/butterfly_stim.txt ====
// Columns: strobe a b side_idx side_last exp_sum exp_diff (hex)
// Modulus FFFF0001, strobe 0 lines are idle cycles
// Block 0 uses idx 000..00C, block 1 uses idx 3F0..3FF
0 00000000 00000000 000 0 00000000 00000000
0 00000000 00000000 000 0 00000000 00000000
1 00000005 00000003 000 0 00000008 00000002
1 12345678 01234567 001 0 13579BDF 11111111
1 7FFFFFFF 00000001 002 0 80000000 7FFFFFFE
0 00000000 00000000 000 0 00000000 00000000
1 00000003 00000005 003 0 00000008 FFFEFFFF
1 00000000 00000001 004 0 00000001 FFFF0000
1 00000000 FFFF0000 005 0 FFFF0000 00000001
1 FFFF0000 00000001 006 0 00000000 FFFEFFFF
1 FFFF0000 FFFF0000 007 0 FFFEFFFF 00000000
0 00000000 00000000 000 0 00000000 00000000
0 00000000 00000000 000 0 00000000 00000000
1 00000000 00000000 008 0 00000000 00000000
1 ABCDEF01 ABCDEF01 009 0 579CDE01 00000000
1 80000000 80000000 00A 0 0000FFFF 00000000
1 80000000 7FFF0001 00B 0 00000000 0000FFFF
1 7FFF0001 80000000 00C 1 00000000 FFFE0002
0 00000000 00000000 000 0 00000000 00000000
1 00000001 FFFF0000 3F0 0 00000000 00000002
1 FFFF0000 00000000 3F1 0 FFFF0000 FFFF0000
1 DEADBEEF 12345678 3F2 0 F0E21567 CC796877
1 12345678 DEADBEEF 3F3 0 F0E21567 3385978A
1 F0000000 F0000000 3F4 0 E000FFFF 00000000
1 FFFEFFFF 00000002 3F5 0 00000000 FFFEFFFD
1 00000002 FFFEFFFF 3F6 0 00000000 00000004
0 00000000 00000000 000 0 00000000 00000000
1 00010000 0000FFFF 3F7 0 0001FFFF 00000001
1 0000FFFF 00010000 3F8 0 0001FFFF FFFF0000
1 C0000000 40000000 3F9 0 0000FFFF 80000000
1 40000000 C0000000 3FA 0 0000FFFF 7FFF0001
1 FFFF0000 FFFEFFFF 3FB 0 FFFEFFFE 00000001
1 FFFEFFFF FFFF0000 3FC 0 FFFEFFFE FFFF0000
0 00000000 00000000 000 0 00000000 00000000
1 00000064 00000064 3FD 0 000000C8 00000000
1 89ABCDEF 01234567 3FE 0 8ACF1356 88888888
1 00000007 0000000A 3FF 1 00000011 FFFEFFFE
0 00000000 00000000 000 0 00000000 00000000
0 00000000 00000000 000 0 00000000 00000000
0 00000000 00000000 000 0 00000000 00000000

// ==== sim.f ====
src/mod_arith_pkg.sv
src/stream_pkg.sv
src/delay_side.sv
src/mod_add.sv
src/mod_sub.sv
src/butterfly_gs.sv
dv/butterfly_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the butterfly testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=butterfly_sim

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert -f sim.f --top-module butterfly_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status, see $LOG"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== dv/butterfly_tb.sv ====
/* Testbench for the butterfly top level, file-driven stimulus,
   scoreboard queue, result and side-data checks, cycle timeout */

module butterfly_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // --------------------------------------------------------------------------
  // Run constants
  // --------------------------------------------------------------------------
  localparam int OP_W = mod_arith_pkg::OP_W_DEF;
  localparam logic [OP_W-1:0] MOD_M = mod_arith_pkg::MOD_M_DEF;
  localparam int PIPE_LAT = int'(mod_arith_pkg::IN_PIPE_DEF) + int'(mod_arith_pkg::OUT_PIPE_DEF);
  // Columns per stim line: strobe, a, b, idx, last, sum, diff
  localparam int FIELDS = 7;
  localparam int NUM_VEC = 40;
  localparam int RST_CYCLES = 2;
  // Quiet cycles after the drain to catch stray pulses
  localparam int TAIL_CYCLES = 4;
  localparam int CYCLE_LIMIT = NUM_VEC + PIPE_LAT + 20;

  // --------------------------------------------------------------------------
  // DUT signals
  // --------------------------------------------------------------------------
  logic clk = 1'b0;
  logic arst_n;
  logic in_avail;
  mod_arith_pkg::operand_t in_op;
  stream_pkg::side_t in_side;
  logic out_avail;
  mod_arith_pkg::result_t out_res;
  stream_pkg::side_t out_side;

  // Expected values that travel with the inputs being driven
  mod_arith_pkg::result_t exp_now_res;
  stream_pkg::side_t exp_now_side;
  int exp_now_vec;

  // Scoreboard, one entry per pair in flight
  mod_arith_pkg::result_t exp_res_q[$];
  stream_pkg::side_t exp_side_q[$];
  int exp_vec_q[$];

  logic [OP_W-1:0] stim_mem [0:NUM_VEC*FIELDS-1];
  int recv_cnt = 0;
  int cycle_cnt = 0;

  butterfly_gs dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_avail  (in_avail),
    .in_op     (in_op),
    .in_side   (in_side),
    .out_avail (out_avail),
    .out_res   (out_res),
    .out_side  (out_side)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference arithmetic and checks
  // --------------------------------------------------------------------------
  function automatic logic [OP_W-1:0] calc_mod_sum(input logic [OP_W-1:0] a,
                                                   input logic [OP_W-1:0] b);
    logic [OP_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    // One reduction is enough for reduced operands
    if (s >= {1'b0, MOD_M}) begin
      s = s - {1'b0, MOD_M};
    end
    return s[OP_W-1:0];
  endfunction

  function automatic logic [OP_W-1:0] calc_mod_diff(input logic [OP_W-1:0] a,
                                                    input logic [OP_W-1:0] b);
    logic [OP_W:0] d;
    if (a >= b) begin
      d = {1'b0, a} - {1'b0, b};
    end else begin
      d = {1'b0, a} + {1'b0, MOD_M} - {1'b0, b};
    end
    return d[OP_W-1:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_result(input string name, input mod_arith_pkg::result_t exp,
                              input mod_arith_pkg::result_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected sum=%h diff=%h actual sum=%h diff=%h",
                          name, exp.sum, exp.diff, act.sum, act.diff));
    end
  endtask

  task automatic check_side(input string name, input stream_pkg::side_t exp,
                            input stream_pkg::side_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected idx=%h last=%b actual idx=%h last=%b",
                          name, exp.idx, exp.last, act.idx, act.last));
    end
  endtask

  // --------------------------------------------------------------------------
  // Timeout
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d pairs still pending",
                          cycle_cnt, exp_res_q.size()));
    end
  end

  // --------------------------------------------------------------------------
  // Monitor, samples values settled since the previous edge
  // --------------------------------------------------------------------------
  always @(posedge clk) begin : monitor
    mod_arith_pkg::result_t exp_res;
    stream_pkg::side_t exp_side;
    int vec;
    if (!arst_n) begin
      if (out_avail !== 1'b0) begin
        abort_run("out_avail was not low while reset was asserted");
      end
    end else begin
      if ($isunknown(out_avail)) begin
        abort_run("out_avail is unknown after reset");
      end else if (out_avail) begin
        if (exp_res_q.size() == 0) begin
          abort_run("out_avail pulsed with no pair in flight");
        end else begin
          exp_res  = exp_res_q.pop_front();
          exp_side = exp_side_q.pop_front();
          vec      = exp_vec_q.pop_front();
          check_result($sformatf("vec%0d result", vec), exp_res, out_res);
          check_side($sformatf("vec%0d side", vec), exp_side, out_side);
          recv_cnt <= recv_cnt + 1;
        end
      end
      // Pair accepted at this edge joins the scoreboard
      if (in_avail) begin
        exp_res_q.push_back(exp_now_res);
        exp_side_q.push_back(exp_now_side);
        exp_vec_q.push_back(exp_now_vec);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Driver
  // --------------------------------------------------------------------------
  initial begin : driver
    int base;
    int sent_cnt;
    mod_arith_pkg::operand_t op;
    mod_arith_pkg::result_t file_res;
    mod_arith_pkg::result_t calc_res;
    stream_pkg::side_t side;
    sent_cnt     = 0;
    arst_n       = 1'b0;
    in_avail     = 1'b0;
    in_op        = '0;
    in_side      = '0;
    exp_now_res  = '0;
    exp_now_side = '0;
    exp_now_vec  = 0;
    $readmemh("dv/butterfly_stim.txt", stim_mem);

    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    for (int v = 0; v < NUM_VEC; v++) begin
      base          = v * FIELDS;
      op.a          = stim_mem[base+1];
      op.b          = stim_mem[base+2];
      side.idx      = stim_mem[base+3][stream_pkg::IDX_W-1:0];
      side.last     = stim_mem[base+4][0];
      file_res.sum  = stim_mem[base+5];
      file_res.diff = stim_mem[base+6];
      // File columns against the modular rules
      if (stim_mem[base][0]) begin
        calc_res.sum  = calc_mod_sum(op.a, op.b);
        calc_res.diff = calc_mod_diff(op.a, op.b);
        check_result($sformatf("vec%0d stim cross-check", v), calc_res, file_res);
        sent_cnt++;
      end
      @(posedge clk);
      in_avail     <= stim_mem[base][0];
      in_op        <= op;
      in_side      <= side;
      exp_now_res  <= file_res;
      exp_now_side <= side;
      exp_now_vec  <= v;
    end
    @(posedge clk);
    in_avail <= 1'b0;

    // Drain, the timeout catches missing pulses
    while (recv_cnt < sent_cnt) begin
      @(posedge clk);
    end
    repeat (TAIL_CYCLES) @(posedge clk);

    if (recv_cnt == sent_cnt && exp_res_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run($sformatf("Sent %0d pairs but received %0d results", sent_cnt, recv_cnt));
    end
  end

endmodule

// ==== src/butterfly_gs.sv ====
/* Butterfly top level, modular sum and difference of one operand pair
   with side data carried through the adder path */

module butterfly_gs #(
  parameter int              OP_W     = mod_arith_pkg::OP_W_DEF,
  parameter logic [OP_W-1:0] MOD_M    = mod_arith_pkg::MOD_M_DEF,
  parameter bit              IN_PIPE  = mod_arith_pkg::IN_PIPE_DEF,
  parameter bit              OUT_PIPE = mod_arith_pkg::OUT_PIPE_DEF
) (
  input  logic                   clk,
  input  logic                   arst_n,
  // Input pair stream
  input  logic                   in_avail,
  input  mod_arith_pkg::operand_t in_op,
  input  stream_pkg::side_t      in_side,
  // Result stream, IN_PIPE + OUT_PIPE cycles later
  output logic                   out_avail,
  output mod_arith_pkg::result_t out_res,
  output stream_pkg::side_t      out_side
);

  // ------------------------------------------------------------------------
  // Sum path, also owns strobe and side data
  // ------------------------------------------------------------------------
  mod_add #(
    .OP_W     (OP_W),
    .MOD_M    (MOD_M),
    .IN_PIPE  (IN_PIPE),
    .OUT_PIPE (OUT_PIPE),
    .SIDE_W   (stream_pkg::SIDE_W),
    .RST_SIDE (stream_pkg::RST_ZERO)
  ) add_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .a         (in_op.a),
    .b         (in_op.b),
    .z         (out_res.sum),
    .in_avail  (in_avail),
    .out_avail (out_avail),
    .in_side   (in_side),
    .out_side  (out_side)
  );

  // ------------------------------------------------------------------------
  // Difference path
  // ------------------------------------------------------------------------
  // Same latency as the adder, so its strobe and side outputs are redundant
  // Strobe still fed in for the operand range check
  mod_sub #(
    .OP_W     (OP_W),
    .MOD_M    (MOD_M),
    .IN_PIPE  (IN_PIPE),
    .OUT_PIPE (OUT_PIPE),
    .SIDE_W   (0),
    .RST_SIDE (stream_pkg::RST_NONE)
  ) sub_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .a         (in_op.a),
    .b         (in_op.b),
    .z         (out_res.diff),
    .in_avail  (in_avail),
    .out_avail (),
    .in_side   ('0),
    .out_side  ()
  );

endmodule

// ==== src/mod_sub.sv ====
/* Pipelined modular subtractor z = (a - b) mod MOD_M,
   with strobe and side data delayed alongside */

module mod_sub #(
  parameter int              OP_W     = mod_arith_pkg::OP_W_DEF,
  parameter logic [OP_W-1:0] MOD_M    = mod_arith_pkg::MOD_M_DEF,
  parameter bit              IN_PIPE  = mod_arith_pkg::IN_PIPE_DEF,
  parameter bit              OUT_PIPE = mod_arith_pkg::OUT_PIPE_DEF,
  parameter int              SIDE_W   = 1,
  parameter logic [1:0]      RST_SIDE = stream_pkg::RST_NONE
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [OP_W-1:0]   a,
  input  logic [OP_W-1:0]   b,
  output logic [OP_W-1:0]   z,
  input  logic              in_avail,
  output logic              out_avail,
  input  logic [SIDE_W-1:0] in_side,
  output logic [SIDE_W-1:0] out_side
);

  // ------------------------------------------------------------------------
  // Stage 0, operand register and correction
  // ------------------------------------------------------------------------
  logic [OP_W-1:0]   s0_a;
  logic [OP_W-1:0]   s0_b;
  logic              s0_avail;
  logic [SIDE_W-1:0] s0_side;
  logic [OP_W:0]     s0_d;
  logic [OP_W-1:0]   s0_d_plus_m;
  logic [OP_W-1:0]   s0_z;

  generate
    if (IN_PIPE) begin : gen_in_pipe
      always_ff @(posedge clk) begin
        s0_a <= a;
        s0_b <= b;
      end
    end else begin : gen_in_comb
      assign s0_a = a;
      assign s0_b = b;
    end
  endgenerate

  delay_side #(
    .LATENCY  (IN_PIPE),
    .SIDE_W   (SIDE_W),
    .RST_SIDE (RST_SIDE)
  ) in_delay_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_avail  (in_avail),
    .out_avail (s0_avail),
    .in_side   (in_side),
    .out_side  (s0_side)
  );

  // Extra top bit catches the borrow
  assign s0_d        = {1'b0, s0_a} - {1'b0, s0_b};
  // Wraps mod 2^OP_W back into [0, MOD_M-1]
  assign s0_d_plus_m = s0_d[OP_W-1:0] + MOD_M;
  assign s0_z        = s0_d[OP_W] ? s0_d_plus_m : s0_d[OP_W-1:0];

  // ------------------------------------------------------------------------
  // Stage 1, result register
  // ------------------------------------------------------------------------
  generate
    if (OUT_PIPE) begin : gen_out_pipe
      always_ff @(posedge clk) begin
        z <= s0_z;
      end
    end else begin : gen_out_comb
      assign z = s0_z;
    end
  endgenerate

  delay_side #(
    .LATENCY  (OUT_PIPE),
    .SIDE_W   (SIDE_W),
    .RST_SIDE (RST_SIDE)
  ) out_delay_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_avail  (s0_avail),
    .out_avail (out_avail),
    .in_side   (s0_side),
    .out_side  (out_side)
  );

  // Single add-back only valid for reduced operands
  a_operand_range : assert property (@(posedge clk) disable iff (!arst_n)
    in_avail |-> (a < MOD_M) && (b < MOD_M))
    else $error("mod_sub: operand not below modulus");

endmodule

// ==== src/mod_add.sv ====
/* Pipelined modular adder z = (a + b) mod MOD_M,
   with strobe and side data delayed alongside */

module mod_add #(
  parameter int              OP_W     = mod_arith_pkg::OP_W_DEF,
  parameter logic [OP_W-1:0] MOD_M    = mod_arith_pkg::MOD_M_DEF,
  parameter bit              IN_PIPE  = mod_arith_pkg::IN_PIPE_DEF,
  parameter bit              OUT_PIPE = mod_arith_pkg::OUT_PIPE_DEF,
  parameter int              SIDE_W   = 1,
  parameter logic [1:0]      RST_SIDE = stream_pkg::RST_NONE
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [OP_W-1:0]   a,
  input  logic [OP_W-1:0]   b,
  output logic [OP_W-1:0]   z,
  input  logic              in_avail,
  output logic              out_avail,
  input  logic [SIDE_W-1:0] in_side,
  output logic [SIDE_W-1:0] out_side
);

  // ------------------------------------------------------------------------
  // Stage 0, operand register and correction
  // ------------------------------------------------------------------------
  logic [OP_W-1:0]   s0_a;
  logic [OP_W-1:0]   s0_b;
  logic              s0_avail;
  logic [SIDE_W-1:0] s0_side;
  logic [OP_W:0]     s0_s;
  logic [OP_W:0]     s0_s_minus_m;
  logic [OP_W-1:0]   s0_z;

  generate
    if (IN_PIPE) begin : gen_in_pipe
      always_ff @(posedge clk) begin
        s0_a <= a;
        s0_b <= b;
      end
    end else begin : gen_in_comb
      assign s0_a = a;
      assign s0_b = b;
    end
  endgenerate

  delay_side #(
    .LATENCY  (IN_PIPE),
    .SIDE_W   (SIDE_W),
    .RST_SIDE (RST_SIDE)
  ) in_delay_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_avail  (in_avail),
    .out_avail (s0_avail),
    .in_side   (in_side),
    .out_side  (s0_side)
  );

  // Full sum needs the carry bit, at most 2*MOD_M - 2
  assign s0_s         = {1'b0, s0_a} + {1'b0, s0_b};
  assign s0_s_minus_m = s0_s - {1'b0, MOD_M};
  // No borrow out of the subtraction means sum >= MOD_M
  assign s0_z = s0_s_minus_m[OP_W] ? s0_s[OP_W-1:0] : s0_s_minus_m[OP_W-1:0];

  // ------------------------------------------------------------------------
  // Stage 1, result register
  // ------------------------------------------------------------------------
  generate
    if (OUT_PIPE) begin : gen_out_pipe
      always_ff @(posedge clk) begin
        z <= s0_z;
      end
    end else begin : gen_out_comb
      assign z = s0_z;
    end
  endgenerate

  delay_side #(
    .LATENCY  (OUT_PIPE),
    .SIDE_W   (SIDE_W),
    .RST_SIDE (RST_SIDE)
  ) out_delay_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_avail  (s0_avail),
    .out_avail (out_avail),
    .in_side   (s0_side),
    .out_side  (out_side)
  );

  // Correction is single-step, so operands must already be reduced
  a_operand_range : assert property (@(posedge clk) disable iff (!arst_n)
    in_avail |-> (a < MOD_M) && (b < MOD_M))
    else $error("mod_add: operand not below modulus");

endmodule

// ==== src/delay_side.sv ====
/* Strobe and side-data delay line, zero or one register stage,
   with the side reset value chosen by parameter */

module delay_side #(
  parameter bit         LATENCY  = 1'b1,
  parameter int         SIDE_W   = 1,
  parameter logic [1:0] RST_SIDE = stream_pkg::RST_NONE
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_avail,
  output logic              out_avail,
  input  logic [SIDE_W-1:0] in_side,
  output logic [SIDE_W-1:0] out_side
);

  generate
    if (!LATENCY) begin : gen_pass
      // Zero depth, strobe and side go straight through
      assign out_avail = in_avail;
      assign out_side  = in_side;
    end else begin : gen_stage
      // Strobe always cleared by reset
      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          out_avail <= 1'b0;
        end else begin
          out_avail <= in_avail;
        end
      end

      // Side register, reset flavour picked by RST_SIDE
      if (RST_SIDE == stream_pkg::RST_ZERO) begin : gen_side_rst0
        always_ff @(posedge clk or negedge arst_n) begin
          if (!arst_n) begin
            out_side <= '0;
          end else begin
            out_side <= in_side;
          end
        end
      end else if (RST_SIDE == stream_pkg::RST_ONE) begin : gen_side_rst1
        always_ff @(posedge clk or negedge arst_n) begin
          if (!arst_n) begin
            out_side <= '1;
          end else begin
            out_side <= in_side;
          end
        end
      end else begin : gen_side_norst
        // Payload only, follows the strobe
        always_ff @(posedge clk) begin
          out_side <= in_side;
        end
      end
    end
  endgenerate

  // Upstream strobe must be clean once out of reset
  a_avail_known : assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(out_avail))
    else $error("delay_side: out_avail unknown after reset");

endmodule

// ==== src/stream_pkg.sv ====
/* Stream side-data struct and the side-register reset encoding */

package stream_pkg;

  // ------------------------------------------------------------------------
  // Side data
  // ------------------------------------------------------------------------
  // Element index within the transform block
  localparam int IDX_W = 10;

  // Travels with each pair, leaves with its results
  typedef struct packed {
    logic [IDX_W-1:0] idx;
    logic             last;  // Final element of the block
  } side_t;

  // Flat width for the delay lines
  localparam int SIDE_W = $bits(side_t);

  // ------------------------------------------------------------------------
  // Side reset value select
  // ------------------------------------------------------------------------
  // Bit 0 resets to zero, bit 1 resets to one, neither means no reset
  localparam logic [1:0] RST_NONE = 2'b00;
  localparam logic [1:0] RST_ZERO = 2'b01;
  localparam logic [1:0] RST_ONE  = 2'b10;

endpackage

// ==== src/mod_arith_pkg.sv ====
/* Modulus-arithmetic defaults for the butterfly datapath,
   plus the operand pair and result pair structs */

package mod_arith_pkg;

  // ------------------------------------------------------------------------
  // Default sizing
  // ------------------------------------------------------------------------
  // One data word
  localparam int OP_W_DEF = 32;

  // Solinas prime 2^32 - 2^16 + 1, top bit set as the units require
  localparam logic [OP_W_DEF-1:0] MOD_M_DEF = 32'hFFFF_0001;

  // One register stage on each side of the combinational correction
  localparam bit IN_PIPE_DEF  = 1'b1;
  localparam bit OUT_PIPE_DEF = 1'b1;

  // ------------------------------------------------------------------------
  // Datapath words
  // ------------------------------------------------------------------------
  // Input pair, both in [0, MOD_M-1]
  typedef struct packed {
    logic [OP_W_DEF-1:0] a;
    logic [OP_W_DEF-1:0] b;
  } operand_t;

  // Butterfly outputs, (a + b) mod M and (a - b) mod M
  typedef struct packed {
    logic [OP_W_DEF-1:0] sum;
    logic [OP_W_DEF-1:0] diff;
  } result_t;

endpackage
